// File: logic/mmc_pkg.sv
// MMC SPI shared definitions
`default_nettype none

package mmc_pkg;

   // protocol constants
   localparam int MMC_WAKE_CLOCKS = 80;
   localparam int MMC_FRAME_BITS  = 48;
   localparam int MMC_BYTE_BITS   = 8;
   localparam int MMC_RESET_HOLD  = 64;

   // engine operation encoding
   localparam logic [2:0] MMC_ST_IDLE    = 3'd0;
   localparam logic [2:0] MMC_ST_WAKE    = 3'd1;
   localparam logic [2:0] MMC_ST_CMD     = 3'd2;
   localparam logic [2:0] MMC_ST_WR      = 3'd3;
   localparam logic [2:0] MMC_ST_RD      = 3'd4;
   localparam logic [2:0] MMC_ST_RELEASE = 3'd5;
   localparam logic [2:0] MMC_ST_FINISH  = 3'd6;

   // command frame, msb first on the wire
   typedef struct packed
   {
      logic        start;
      logic        transmit;
      logic [5:0]  index;
      logic [31:0] arg;
      logic [6:0]  crc7;
      logic        stop;
   } mmc_frame_fields_t;

   // builder fills fields, engine shifts raw
   typedef union packed
   {
      logic [MMC_FRAME_BITS-1:0] raw;
      mmc_frame_fields_t         fields;
   } mmc_frame_u;

   // one-cycle job strobes, init has priority
   typedef struct packed
   {
      logic init;
      logic send;
      logic wr;
      logic rd;
   } mmc_req_t;

   // card side outputs
   typedef struct packed
   {
      logic cs_n;
      logic sclk;
      logic mosi;
   } mmc_pins_t;

endpackage

`default_nettype wire

// File: logic/mmc_clock_gen.sv
// MMC serial clock tick generator
`default_nettype none

module mmc_clock_gen
   import mmc_pkg::*;
#(
   parameter int SLOW_DIV = 128,
   parameter int FAST_DIV = 4
)
(
   input  wire logic mmc_clk,
   input  wire logic reset,
   input  wire logic speed,
   output logic      tick,
   output logic      ready
);

   localparam int DIV_MAX = (SLOW_DIV > FAST_DIV) ? SLOW_DIV : FAST_DIV;
   localparam int DIV_W   = $clog2(DIV_MAX + 1);
   localparam int HOLD_W  = $clog2(MMC_RESET_HOLD);

   localparam logic [DIV_W-1:0] SLOW_LOAD = DIV_W'(SLOW_DIV - 1);
   localparam logic [DIV_W-1:0] FAST_LOAD = DIV_W'(FAST_DIV - 1);
   localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(MMC_RESET_HOLD - 1);

   logic [DIV_W-1:0]  div_cnt;
   logic [HOLD_W-1:0] hold_cnt;

   // reload picks the rate, so speed changes land on a tick
   always_ff @(posedge mmc_clk)
   begin
      if (reset)
         div_cnt <= SLOW_LOAD;
      else if (div_cnt == '0)
         div_cnt <= speed ? FAST_LOAD : SLOW_LOAD;
      else
         div_cnt <= div_cnt - 1'b1;
   end

   assign tick = (div_cnt == '0);

   // stretched reset, card needs time after power-up
   always_ff @(posedge mmc_clk)
   begin
      if (reset)
      begin
         hold_cnt <= '0;
         ready    <= 1'b0;
      end
      else if (!ready)
      begin
         hold_cnt <= hold_cnt + 1'b1;
         if (hold_cnt == HOLD_LAST)
            ready <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/mmc_cmd_builder.sv
// MMC command frame builder
`default_nettype none

module mmc_cmd_builder
   import mmc_pkg::*;
(
   input  wire logic [5:0]  cmd_index,
   input  wire logic [31:0] cmd_arg,
   output mmc_frame_u       frame
);

   localparam int HEAD_BITS = MMC_FRAME_BITS - 8;

   // generator x^7 + x^3 + 1
   localparam logic [6:0] CRC7_POLY = 7'h09;

   logic [HEAD_BITS-1:0] head;
   logic [6:0]           crc;

   // serial crc7, msb of the head first
   function automatic logic [6:0] crc7_calc(input logic [HEAD_BITS-1:0] bits);
      logic [6:0] acc;
      logic       fb;
      acc = '0;
      for (int i = HEAD_BITS - 1; i >= 0; i--)
      begin
         fb  = bits[i] ^ acc[6];
         acc = {acc[5:0], 1'b0};
         if (fb)
            acc = acc ^ CRC7_POLY;
      end
      return acc;
   endfunction

   // start 0, transmission 1, then index and argument
   assign head = {1'b0, 1'b1, cmd_index, cmd_arg};

   assign crc = crc7_calc(head);

   always_comb
   begin
      frame.fields.start    = 1'b0;
      frame.fields.transmit = 1'b1;
      frame.fields.index    = cmd_index;
      frame.fields.arg      = cmd_arg;
      frame.fields.crc7     = crc;
      frame.fields.stop     = 1'b1;
   end

endmodule

`default_nettype wire

// File: logic/mmc_spi_engine.sv
// MMC SPI transfer sequencer
`default_nettype none

module mmc_spi_engine
   import mmc_pkg::*;
(
   input  wire logic       mmc_clk,
   input  wire logic       reset,
   input  wire logic       tick,
   input  wire logic       ready,
   input  wire mmc_req_t   req,
   input  wire mmc_frame_u frame,
   input  wire logic [7:0] data_in,
   input  wire logic       miso,
   output mmc_pins_t       pins,
   output logic [7:0]      data_out,
   output logic            done
);

   localparam int CNT_W = $clog2(MMC_WAKE_CLOCKS + 1);

   logic [2:0]                state;
   logic [2:0]                start_state;
   logic [CNT_W-1:0]          bit_cnt;
   logic [CNT_W-1:0]          bit_limit;
   logic [MMC_FRAME_BITS-1:0] tx_shift;
   logic [MMC_FRAME_BITS-1:0] tx_load;
   logic [MMC_BYTE_BITS-1:0]  rx_shift;
   logic                      in_job;
   logic                      accept;
   logic                      rise;
   logic                      fall;

   // job selection, first strobe wins
   always_comb
   begin
      start_state = MMC_ST_IDLE;
      tx_load     = '1;
      if (req.init)
         start_state = MMC_ST_WAKE;
      else if (req.send)
      begin
         start_state = MMC_ST_CMD;
         tx_load     = frame.raw;
      end
      else if (req.wr)
      begin
         start_state = MMC_ST_WR;
         tx_load     = {data_in, {(MMC_FRAME_BITS - MMC_BYTE_BITS){1'b1}}};
      end
      else if (req.rd)
         start_state = MMC_ST_RD;
   end

   // number of sclk periods per job
   always_comb
   begin
      case (state)
         MMC_ST_WAKE: bit_limit = CNT_W'(MMC_WAKE_CLOCKS);
         MMC_ST_CMD:  bit_limit = CNT_W'(MMC_FRAME_BITS);
         default:     bit_limit = CNT_W'(MMC_BYTE_BITS);
      endcase
   end

   assign in_job = (state == MMC_ST_WAKE) || (state == MMC_ST_CMD) ||
                   (state == MMC_ST_WR) || (state == MMC_ST_RD);

   assign accept = (state == MMC_ST_IDLE) && ready && (start_state != MMC_ST_IDLE);

   // mode 0 edges
   assign rise = tick && in_job && !pins.sclk;
   assign fall = tick && in_job && pins.sclk;

   always_ff @(posedge mmc_clk)
   begin
      if (reset)
      begin
         state     <= MMC_ST_IDLE;
         bit_cnt   <= '0;
         pins.cs_n <= 1'b1;
         pins.sclk <= 1'b0;
         pins.mosi <= 1'b1;
         data_out  <= '0;
         done      <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            MMC_ST_IDLE:
            begin
               if (accept)
               begin
                  state     <= start_state;
                  bit_cnt   <= '0;
                  // first bit set up ahead of the first rising edge
                  pins.mosi <= tx_load[MMC_FRAME_BITS-1];
                  pins.cs_n <= (start_state == MMC_ST_WAKE);
               end
            end
            MMC_ST_WAKE, MMC_ST_CMD, MMC_ST_WR, MMC_ST_RD:
            begin
               if (rise)
               begin
                  pins.sclk <= 1'b1;
                  bit_cnt   <= bit_cnt + 1'b1;
               end
               else if (fall)
               begin
                  pins.sclk <= 1'b0;
                  if (bit_cnt == bit_limit)
                  begin
                     state <= MMC_ST_RELEASE;
                     if (state == MMC_ST_RD)
                        data_out <= rx_shift;
                  end
                  else
                     pins.mosi <= tx_shift[MMC_FRAME_BITS-2];
               end
            end
            MMC_ST_RELEASE:
            begin
               if (tick)
               begin
                  pins.cs_n <= 1'b1;
                  pins.mosi <= 1'b1;
                  state     <= MMC_ST_FINISH;
               end
            end
            MMC_ST_FINISH:
            begin
               if (tick)
               begin
                  done  <= 1'b1;
                  state <= MMC_ST_IDLE;
               end
            end
            default:
               state <= MMC_ST_IDLE;
         endcase
      end
   end

   // shared tx register, ones fill behind the data
   always_ff @(posedge mmc_clk)
   begin
      if (accept)
         tx_shift <= tx_load;
      else if (fall)
         tx_shift <= {tx_shift[MMC_FRAME_BITS-2:0], 1'b1};
   end

   // miso sampled with the rising edge
   always_ff @(posedge mmc_clk)
   begin
      if (rise)
         rx_shift <= {rx_shift[MMC_BYTE_BITS-2:0], miso};
   end

endmodule

`default_nettype wire

// File: logic/mmc_spi_top.sv
// MMC SPI controller top level
`default_nettype none

module mmc_spi_top
   import mmc_pkg::*;
#(
   parameter int SLOW_DIV = 128,
   parameter int FAST_DIV = 4
)
(
   input  wire logic        mmc_clk,
   input  wire logic        reset,
   input  wire logic        speed,
   input  wire logic        miso,
   input  wire mmc_req_t    req,
   input  wire logic [5:0]  cmd_index,
   input  wire logic [31:0] cmd_arg,
   input  wire logic [7:0]  data_in,
   output mmc_pins_t        pins,
   output logic [7:0]       data_out,
   output logic             done
);

   logic       tick;
   logic       ready;
   mmc_frame_u frame;

   mmc_clock_gen #(
      .SLOW_DIV (SLOW_DIV),
      .FAST_DIV (FAST_DIV)
   ) mmc_clock_gen_i (
      .mmc_clk (mmc_clk),
      .reset   (reset),
      .speed   (speed),
      .tick    (tick),
      .ready   (ready)
   );

   mmc_cmd_builder mmc_cmd_builder_i (
      .cmd_index (cmd_index),
      .cmd_arg   (cmd_arg),
      .frame     (frame)
   );

   mmc_spi_engine mmc_spi_engine_i (
      .mmc_clk  (mmc_clk),
      .reset    (reset),
      .tick     (tick),
      .ready    (ready),
      .req      (req),
      .frame    (frame),
      .data_in  (data_in),
      .miso     (miso),
      .pins     (pins),
      .data_out (data_out),
      .done     (done)
   );

endmodule

`default_nettype wire

// File: verification/mmc_card_model.sv
// Behavioral SPI card
`default_nettype none

module mmc_card_model
   import mmc_pkg::*;
(
   input  wire mmc_pins_t           pins,
   output logic                     miso,
   output logic [MMC_FRAME_BITS-1:0] rx_frame,
   output int                       wake_count,
   output int                       cs_fall_count,
   output int                       last_bits
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] tx_byte;
   logic [7:0] tx_shift;
   int         bit_count;

   initial
   begin
      miso          = 1'b1;
      rx_frame      = '0;
      wake_count    = 0;
      cs_fall_count = 0;
      last_bits     = 0;
      bit_count     = 0;
      tx_byte       = 8'h5a;
      tx_shift      = 8'h5a;
   end

   // first miso bit must be valid before the first rising edge
   always @(negedge pins.cs_n)
   begin
      cs_fall_count = cs_fall_count + 1;
      bit_count     = 0;
      tx_shift      = tx_byte;
      miso          = tx_shift[7];
   end

   always @(posedge pins.sclk)
   begin
      if (pins.cs_n)
      begin
         if (pins.mosi)
            wake_count = wake_count + 1;
      end
      else
      begin
         rx_frame  = {rx_frame[MMC_FRAME_BITS-2:0], pins.mosi};
         bit_count = bit_count + 1;
      end
   end

   always @(negedge pins.sclk)
   begin
      if (!pins.cs_n)
      begin
         tx_shift = {tx_shift[6:0], 1'b1};
         miso     = tx_shift[7];
      end
   end

   // a full byte turns into the next answer, inverted
   always @(posedge pins.cs_n)
   begin
      if (bit_count > 0)
      begin
         last_bits = bit_count;
         if (bit_count == MMC_BYTE_BITS)
            tx_byte = ~rx_frame[7:0];
         $display("card: %0d bits received", bit_count);
         bit_count = 0;
      end
   end

endmodule

`default_nettype wire

// File: verification/mmc_spi_tb.sv
// MMC SPI controller testbench
`default_nettype none

module mmc_spi_tb
   import mmc_pkg::*;
;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SLOW_DIV     = 8;
   localparam int FAST_DIV     = 2;
   localparam int DONE_TIMEOUT = 5000;
   localparam int NUM_ROWS     = 13;

   localparam logic [1:0] OP_INIT = 2'd0;
   localparam logic [1:0] OP_SEND = 2'd1;
   localparam logic [1:0] OP_WR   = 2'd2;
   localparam logic [1:0] OP_RD   = 2'd3;

   typedef struct packed
   {
      logic [1:0]  op;
      logic        fast;
      logic        busy;
      logic [5:0]  index;
      logic [31:0] arg;
      logic [7:0]  data;
   } row_t;

   logic        mmc_clk;
   logic        reset;
   logic        speed;
   logic        miso;
   mmc_req_t    req;
   logic [5:0]  cmd_index;
   logic [31:0] cmd_arg;
   logic [7:0]  data_in;
   mmc_pins_t   pins;
   logic [7:0]  data_out;
   logic        done;

   logic [MMC_FRAME_BITS-1:0] rx_frame;
   int          wake_count;
   int          cs_fall_count;
   int          last_bits;

   row_t        rows [NUM_ROWS];
   string       op_names [4] = '{"init", "send", "wr", "rd"};
   logic [31:0] lcg_state = 32'hfe8e;
   logic [7:0]  next_miso = 8'h5a;
   int          error_count = 0;
   int          check_count = 0;
   int          done_count = 0;
   int          cycle_count = 0;
   int          last_rise = -1;
   int          spacing_min = 1000;
   int          spacing_max = 0;

   mmc_spi_top #(
      .SLOW_DIV (SLOW_DIV),
      .FAST_DIV (FAST_DIV)
   ) mmc_spi_top_i (
      .mmc_clk   (mmc_clk),
      .reset     (reset),
      .speed     (speed),
      .miso      (miso),
      .req       (req),
      .cmd_index (cmd_index),
      .cmd_arg   (cmd_arg),
      .data_in   (data_in),
      .pins      (pins),
      .data_out  (data_out),
      .done      (done)
   );

   mmc_card_model mmc_card_model_i (
      .pins          (pins),
      .miso          (miso),
      .rx_frame      (rx_frame),
      .wake_count    (wake_count),
      .cs_fall_count (cs_fall_count),
      .last_bits     (last_bits)
   );

   initial
   begin
      mmc_clk = 1'b0;
      forever #5 mmc_clk = ~mmc_clk;
   end

   always @(posedge mmc_clk)
   begin
      cycle_count = cycle_count + 1;
      if (done)
         done_count = done_count + 1;
   end

   // spacing of rising sclk edges within one job
   always @(posedge pins.sclk)
   begin
      if (last_rise >= 0)
      begin
         if (cycle_count - last_rise < spacing_min)
            spacing_min = cycle_count - last_rise;
         if (cycle_count - last_rise > spacing_max)
            spacing_max = cycle_count - last_rise;
      end
      last_rise = cycle_count;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic row_t make_row(input logic [1:0] op, input logic fast,
                                     input logic busy, input logic [5:0] index,
                                     input logic [7:0] data);
      row_t r;
      r.op    = op;
      r.fast  = fast;
      r.busy  = busy;
      r.index = index;
      r.arg   = lcg_next();
      r.data  = data;
      return r;
   endfunction

   // long division by x^7 + x^3 + 1 over the message with 7 zeros appended
   function automatic logic [6:0] ref_crc7(input logic [39:0] msg);
      logic [46:0] rem;
      rem = {msg, 7'b0};
      for (int i = 46; i >= 7; i--)
      begin
         if (rem[i])
            rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
      return rem[6:0];
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      check_count = check_count + 1;
      if (actual !== expected)
      begin
         error_count = error_count + 1;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   task automatic run_row(input int n, input row_t r);
      int          errs0;
      int          dones0;
      int          wake0;
      int          falls0;
      int          wait_cnt;
      logic [47:0] exp_frame;
      errs0  = error_count;
      dones0 = done_count;
      wake0  = wake_count;
      falls0 = cs_fall_count;
      speed  = r.fast;
      @(posedge mmc_clk);
      #1;
      cmd_index   = r.index;
      cmd_arg     = r.arg;
      data_in     = r.data;
      last_rise   = -1;
      spacing_min = 1000;
      spacing_max = 0;
      case (r.op)
         OP_INIT: req.init = 1'b1;
         OP_SEND: req.send = 1'b1;
         OP_WR:   req.wr = 1'b1;
         default: req.rd = 1'b1;
      endcase
      @(posedge mmc_clk);
      #1;
      req = '0;
      if (r.busy)
      begin
         repeat (30) @(posedge mmc_clk);
         #1;
         req.send  = 1'b1;
         cmd_index = ~r.index;
         cmd_arg   = ~r.arg;
         @(posedge mmc_clk);
         #1;
         req = '0;
      end
      wait_cnt = 0;
      while (done_count == dones0 && wait_cnt < DONE_TIMEOUT)
      begin
         @(posedge mmc_clk);
         #1;
         wait_cnt = wait_cnt + 1;
      end
      if (done_count == dones0)
      begin
         $display("timeout: no done pulse within %0d cycles in row %0d", DONE_TIMEOUT, n);
         $display("Test failed");
         $finish;
      end
      // quiet time lets a late or extra done show up
      repeat (40) @(posedge mmc_clk);
      #1;
      check_value("done pulses", done_count - dones0, 1);
      check_value("pins", pins, 3'b101);
      check_value("cs_n falls", cs_fall_count - falls0, (r.op == OP_INIT) ? 0 : 1);
      check_value("sclk spacing min", spacing_min, r.fast ? 2 * FAST_DIV : 2 * SLOW_DIV);
      check_value("sclk spacing max", spacing_max, r.fast ? 2 * FAST_DIV : 2 * SLOW_DIV);
      case (r.op)
         OP_INIT:
         begin
            check_value("wake_count", wake_count - wake0, MMC_WAKE_CLOCKS);
         end
         OP_SEND:
         begin
            exp_frame = {2'b01, r.index, r.arg, ref_crc7({2'b01, r.index, r.arg}), 1'b1};
            check_value("card frame", rx_frame, exp_frame);
            check_value("card bits", last_bits, MMC_FRAME_BITS);
         end
         OP_WR:
         begin
            check_value("card byte", rx_frame[7:0], r.data);
            check_value("card bits", last_bits, MMC_BYTE_BITS);
            next_miso = ~r.data;
         end
         default:
         begin
            check_value("data_out", data_out, next_miso);
            check_value("card bits", last_bits, MMC_BYTE_BITS);
            // mosi idles high during a read
            next_miso = ~8'hff;
         end
      endcase
      $display("row %0d %s %s: %s", n, op_names[r.op], r.fast ? "fast" : "slow",
               (error_count == errs0) ? "ok" : "mismatch");
   endtask

   initial
   begin
      reset     = 1'b1;
      speed     = 1'b0;
      req       = '0;
      cmd_index = '0;
      cmd_arg   = '0;
      data_in   = '0;
      rows[0]  = make_row(OP_RD,   1'b0, 1'b0, 6'd0,  8'h00);
      rows[1]  = make_row(OP_INIT, 1'b0, 1'b0, 6'd0,  8'h00);
      rows[2]  = make_row(OP_SEND, 1'b0, 1'b0, 6'd0,  8'h00);
      rows[3]  = make_row(OP_SEND, 1'b1, 1'b0, 6'd8,  8'h00);
      rows[4]  = make_row(OP_WR,   1'b0, 1'b0, 6'd0,  8'ha5);
      rows[5]  = make_row(OP_RD,   1'b0, 1'b0, 6'd0,  8'h00);
      rows[6]  = make_row(OP_WR,   1'b1, 1'b0, 6'd0,  8'h3c);
      rows[7]  = make_row(OP_RD,   1'b1, 1'b0, 6'd0,  8'h00);
      rows[8]  = make_row(OP_SEND, 1'b1, 1'b1, 6'd17, 8'h00);
      rows[9]  = make_row(OP_SEND, 1'b0, 1'b0, 6'd55, 8'h00);
      rows[10] = make_row(OP_INIT, 1'b1, 1'b0, 6'd0,  8'h00);
      rows[11] = make_row(OP_WR,   1'b1, 1'b0, 6'd0,  8'hc9);
      rows[12] = make_row(OP_RD,   1'b1, 1'b0, 6'd0,  8'h00);
      repeat (16) @(posedge mmc_clk);
      #1;
      reset = 1'b0;
      check_value("done", done, 0);
      check_value("data_out", data_out, 0);
      check_value("pins", pins, 3'b101);
      $display("reset state: %s", (error_count == 0) ? "ok" : "mismatch");
      repeat (MMC_RESET_HOLD) @(posedge mmc_clk);
      #1;
      for (int i = 0; i < NUM_ROWS; i++)
         run_row(i, rows[i]);
      $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_count, error_count);
      if (error_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
logic/mmc_pkg.sv
logic/mmc_clock_gen.sv
logic/mmc_cmd_builder.sv
logic/mmc_spi_engine.sv
logic/mmc_spi_top.sv
verification/mmc_card_model.sv
verification/mmc_spi_tb.sv
